// ==== bench/fpu_props.sv ====
`timescale 1ns/1ps

module fpu_props (
    input logic              clk,
    input logic              rst,
    input fpu_pkg::fpu_op_e  op,
    input fpu_pkg::fp_word_t a,
    input fpu_pkg::fp_word_t b,
    input fpu_pkg::fp_word_t c
);
    import fpu_pkg::*;

    int   fail_count = 0;   // failed assertions so far
    logic used_op;   // opcode with a result unit behind it
    logic cmp_op;
    logic same_word;

    assign used_op   = op inside {OP_ADD, OP_MUL, OP_ITF, OP_FTI, OP_GT, OP_LT, OP_NE, OP_EQ};
    assign cmp_op    = op inside {OP_GT, OP_LT, OP_NE, OP_EQ};
    assign same_word = (a == b);

    a_reset_clear: assert property (@(posedge clk) rst |=> c == FALSE_WORD)
        else begin
            fail_count++;
            $error("c not zero after a reset edge");
        end

    a_unused_zero: assert property (@(posedge clk) !used_op |=> c == FALSE_WORD)
        else begin
            fail_count++;
            $error("unused opcode gave a nonzero c");
        end

    // equal words are neither greater nor less, only eq holds
    a_cmp_equal: assert property (@(posedge clk)
        (cmp_op && !rst && same_word)
            |=> c == (($past(op) == OP_EQ) ? TRUE_WORD : FALSE_WORD))
        else begin
            fail_count++;
            $error("compare of equal words gave the wrong flag word in c");
        end

endmodule

// ==== bench/fpu_tb.sv ====
`timescale 1ns/1ps

module fpu_tb;
    import fpu_pkg::*;

    localparam int          MAX_TESTS  = 64;
    localparam int          RST_CYCLES = 16;
    localparam int          CLK_NS     = 20;
    localparam int unsigned SEED       = 32'hcab4_faf8;
    localparam string       VEC_FILE   = "bench/fpu_vectors.txt";

    logic     clk;
    logic     rst;
    fpu_op_e  op;
    fp_word_t a;
    fp_word_t b;
    fp_word_t c;

    logic [31:0] vec [0:4*MAX_TESTS-1];   // op, a, b, expected c per test
    int          n_tests;
    int          errors;
    bit          loaded;

    fpu_top dut0 (
        .clk (clk),
        .rst (rst),
        .op  (op),
        .a   (a),
        .b   (b),
        .c   (c)
    );

    bind fpu_top fpu_props props0 (
        .clk (clk),
        .rst (rst),
        .op  (op),
        .a   (a),
        .b   (b),
        .c   (c)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS/2) clk = ~clk;
        end
    end

    task automatic check_float(input string where, input fp_word_t expected,
                               input fp_word_t actual);
        if (actual !== expected) begin
            $display("mismatch c (%s): expected %h, got %h", where, expected, actual);
            errors++;
        end
    endtask

    task automatic check_int(input string where, input int_word_t expected,
                             input int_word_t actual);
        if (actual !== expected) begin
            $display("mismatch c (%s): expected %h, got %h", where, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string where, input fp_word_t expected,
                              input fp_word_t actual);
        if (expected != TRUE_WORD && expected != FALSE_WORD) begin
            $display("%s expects a flag word that is neither all ones nor all zeros", where);
            errors++;
        end else if (actual !== expected) begin
            $display("mismatch c (%s): expected %h, got %h", where, expected, actual);
            errors++;
        end
    endtask

    // pick the compare task that fits the kind of result
    task automatic score_vector(input int i);
        fpu_op_e  vop;
        fp_word_t expect_c;
        string    where;
        vop      = fpu_op_e'(vec[4*i][3:0]);
        expect_c = vec[4*i+3];
        where    = $sformatf("vector %0d", i);
        case (vop)
            OP_ADD, OP_MUL, OP_ITF: check_float(where, expect_c, c);
            OP_FTI:  check_int(where, int_word_t'(expect_c), int_word_t'(c));
            default: check_flag(where, expect_c, c);   // compares and unused codes
        endcase
    endtask

    initial begin
        int fd;
        int assert_fails;
        rst      = 1'b1;
        op       = fpu_op_e'(4'd0);
        a        = '0;
        b        = '0;
        errors   = 0;
        n_tests  = 0;
        loaded   = 1'b0;
        void'($urandom(SEED));

        for (int i = 0; i < 4*MAX_TESTS; i++) begin
            vec[i] = ~i;   // unread slots stay above any opcode
        end

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("vector file %s could not be opened", VEC_FILE);
            errors++;
        end else begin
            $fclose(fd);
            $readmemh(VEC_FILE, vec);
            while (n_tests < MAX_TESTS && vec[4*n_tests] <= 32'hf) begin
                n_tests++;
            end
            if (n_tests == 0) begin
                $display("vector file %s holds no tests", VEC_FILE);
                errors++;
            end
        end
        loaded = 1'b1;

        // idle opcode with random operands while reset is held
        repeat (RST_CYCLES) begin
            @(posedge clk);
            #1;
            check_flag("reset", FALSE_WORD, c);
            a = $urandom();
            b = $urandom();
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_flag("first cycle after reset", FALSE_WORD, c);

        // one test per cycle, result one edge later
        for (int i = 0; i < n_tests; i++) begin
            op = fpu_op_e'(vec[4*i][3:0]);
            a  = vec[4*i+1];
            b  = vec[4*i+2];
            @(posedge clk);
            #1;
            score_vector(i);
        end
        op = fpu_op_e'(4'd0);

        assert_fails = dut0.props0.fail_count;
        $display("%0d tests run, %0d check errors, %0d assertion failures",
                 n_tests, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = (RST_CYCLES + n_tests + 10) * CLK_NS;   // reset, tests and some slack
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== bench/fpu_vectors.txt ====
// columns: op a b expected_c, all hex, one test per line
// op: 1 add, 2 mul, 4 int to float, 5 float to int, 6 gt, 7 lt, 8 ne, 9 eq
1 3fc00000 40100000 40700000  // 1.5 + 2.25
1 3f800000 bf800000 00000000  // 1.0 + -1.0
1 3f800000 c0400000 c0000000  // 1.0 + -3.0
1 40c00000 bf000000 40b00000  // 6.0 + -0.5
1 bfc00000 c0100000 c0700000  // -1.5 + -2.25
1 40400000 c0300000 3e800000  // 3.0 + -2.75
2 40400000 bf000000 bfc00000  // 3.0 * -0.5
2 3fc00000 3fc00000 40100000  // 1.5 * 1.5
2 3fc00000 3f800001 3fc00001  // low product bits truncated
4 00000000 00000000 00000000  // 0
4 fffffffa 00000000 c0c00000  // -6
4 7fffffff 00000000 4effffff  // max int truncated
5 40300000 00000000 00000002  // 2.75
5 c0300000 00000000 fffffffe  // -2.75
5 3f000000 00000000 00000000  // 0.5
6 bf800000 3f000000 00000000
6 3f000000 bf800000 ffffffff
6 c0300000 c0400000 ffffffff
6 40300000 40300000 00000000
7 bf800000 3f000000 ffffffff
7 c0400000 c0300000 ffffffff
7 c0300000 c0300000 00000000
8 bf800000 3f000000 ffffffff
8 c0400000 c0300000 ffffffff
8 40300000 40300000 00000000
9 bf800000 3f000000 00000000
9 c0400000 c0300000 00000000
9 c0300000 c0300000 ffffffff
0 3f800000 3f800000 00000000
3 40400000 3f000000 00000000
a 3fc00000 40100000 00000000
b 40300000 c0300000 00000000
c bf800000 3f800000 00000000
d 40c00000 bf000000 00000000
e c0400000 c0300000 00000000
f ffffffff ffffffff 00000000

// ==== build.f ====
hdl/fpu_pkg.sv
hdl/fp_normalize.sv
hdl/fp_add.sv
hdl/fp_mul.sv
hdl/fp_convert.sv
hdl/fp_compare.sv
hdl/fpu_top.sv
bench/fpu_props.sv
bench/fpu_tb.sv

// ==== hdl/fp_add.sv ====
`timescale 1ns/1ps

module fp_add (
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    output fpu_pkg::fp_word_t sum
);
    import fpu_pkg::*;

    fp_exp_t   exp_a;
    fp_exp_t   exp_b;
    fp_exp_t   exp_c;      // exponent before normalizing
    wide_man_t man_a;
    wide_man_t man_b;
    wide_man_t al_a;       // aligned magnitudes
    wide_man_t al_b;
    wide_man_t man_c;
    logic      sign_c;

    assign exp_a = a[FP_W-2 -: EXP_W];
    assign exp_b = b[FP_W-2 -: EXP_W];

    // hidden one sits at the point
    assign man_a = wide_man_t'({1'b1, a[FRAC_W-1:0]}) << (POINT - FRAC_W);
    assign man_b = wide_man_t'({1'b1, b[FRAC_W-1:0]}) << (POINT - FRAC_W);

    // shift the smaller operand down to the larger exponent
    always_comb begin
        if (exp_a >= exp_b) begin
            al_a  = man_a;
            al_b  = man_b >> (exp_a - exp_b);
            exp_c = exp_a;
        end else begin
            al_a  = man_a >> (exp_b - exp_a);
            al_b  = man_b;
            exp_c = exp_b;
        end
    end

    // same sign adds, different sign subtracts smaller from larger
    always_comb begin
        if (a[FP_W-1] == b[FP_W-1]) begin
            man_c  = al_a + al_b;
            sign_c = a[FP_W-1];
        end else if (al_a > al_b) begin
            man_c  = al_a - al_b;
            sign_c = a[FP_W-1];
        end else if (al_a < al_b) begin
            man_c  = al_b - al_a;
            sign_c = b[FP_W-1];
        end else begin
            man_c  = '0;       // exact cancel
            sign_c = 1'b0;
        end
    end

    fp_normalize u_norm (
        .sign (sign_c),
        .exp  (exp_c),
        .man  (man_c),
        .word (sum)
    );

endmodule

// ==== hdl/fp_compare.sv ====
`timescale 1ns/1ps

module fp_compare (
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    output logic              gt,
    output logic              lt,
    output logic              eq
);
    import fpu_pkg::*;

    logic mag_gt;   // |a| > |b|
    logic mag_lt;

    // exponent first, fraction breaks ties
    always_comb begin
        mag_gt = 1'b0;
        mag_lt = 1'b0;
        if (a[FP_W-2 -: EXP_W] > b[FP_W-2 -: EXP_W]) begin
            mag_gt = 1'b1;
        end else if (a[FP_W-2 -: EXP_W] < b[FP_W-2 -: EXP_W]) begin
            mag_lt = 1'b1;
        end else if (a[FRAC_W-1:0] > b[FRAC_W-1:0]) begin
            mag_gt = 1'b1;
        end else if (a[FRAC_W-1:0] < b[FRAC_W-1:0]) begin
            mag_lt = 1'b1;
        end
    end

    assign eq = (a == b);

    always_comb begin
        if (a[FP_W-1] != b[FP_W-1]) begin
            gt = ~a[FP_W-1];   // positive side wins
            lt = a[FP_W-1];
        end else if (a[FP_W-1]) begin
            gt = mag_lt;       // both negative, order flips
            lt = mag_gt;
        end else begin
            gt = mag_gt;
            lt = mag_lt;
        end
    end

endmodule

// ==== hdl/fp_convert.sv ====
`timescale 1ns/1ps

module fp_convert (
    input  fpu_pkg::fp_word_t  a,
    output fpu_pkg::fp_word_t  itf,
    output fpu_pkg::int_word_t fti
);
    import fpu_pkg::*;

    fp_word_t  mag_i;      // |a| read as signed integer
    wide_man_t man_i;
    fp_exp_t   exp_f;
    wide_man_t man_f;
    wide_man_t shifted;
    fp_word_t  mag_f;      // integer part of |a| as float

    // int to float, magnitude placed in the integer half
    assign mag_i = a[FP_W-1] ? -a : a;
    assign man_i = wide_man_t'(mag_i) << POINT;

    fp_normalize u_norm (
        .sign (a[FP_W-1]),
        .exp  (fp_exp_t'(EXP_BIAS)),   // value equals the integer part as is
        .man  (man_i),
        .word (itf)
    );

    // float to int
    assign exp_f = a[FP_W-2 -: EXP_W];
    assign man_f = wide_man_t'({1'b1, a[FRAC_W-1:0]}) << (POINT - FRAC_W);

    always_comb begin
        if (exp_f >= fp_exp_t'(EXP_BIAS)) begin
            shifted = man_f << (exp_f - fp_exp_t'(EXP_BIAS));
        end else begin
            shifted = man_f >> (fp_exp_t'(EXP_BIAS) - exp_f);   // below one ends up zero
        end
    end

    assign mag_f = shifted[WIDE_W-1:POINT];   // fraction bits discarded

    // negate after truncation, so rounding is toward zero
    assign fti = a[FP_W-1] ? -int_word_t'(mag_f) : int_word_t'(mag_f);

endmodule

// ==== hdl/fp_mul.sv ====
`timescale 1ns/1ps

module fp_mul (
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    output fpu_pkg::fp_word_t prod
);
    import fpu_pkg::*;

    logic [FRAC_W:0]       man_a;   // 1.f, hidden one included
    logic [FRAC_W:0]       man_b;
    logic [2*FRAC_W+1:0]   full;    // point at bit 2*FRAC_W
    wide_man_t             man_c;
    fp_exp_t               exp_c;
    logic                  sign_c;

    assign man_a = {1'b1, a[FRAC_W-1:0]};
    assign man_b = {1'b1, b[FRAC_W-1:0]};

    assign full  = man_a * man_b;

    // move the product point down to the working point, low bits drop
    assign man_c = wide_man_t'(full >> (2*FRAC_W - POINT));

    // biased sum counts the bias twice
    assign exp_c = fp_exp_t'(a[FP_W-2 -: EXP_W] + b[FP_W-2 -: EXP_W] - EXP_BIAS);

    assign sign_c = a[FP_W-1] ^ b[FP_W-1];

    fp_normalize u_norm (
        .sign (sign_c),
        .exp  (exp_c),
        .man  (man_c),
        .word (prod)
    );

endmodule

// ==== hdl/fp_normalize.sv ====
`timescale 1ns/1ps

module fp_normalize (
    input  logic               sign,
    input  fpu_pkg::fp_exp_t   exp,
    input  fpu_pkg::wide_man_t man,
    output fpu_pkg::fp_word_t  word
);
    import fpu_pkg::*;

    logic [$clog2(WIDE_W)-1:0] lead;   // position of leading one
    wide_man_t                 norm;
    fp_exp_t                   exp_n;

    // priority search, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < WIDE_W; i++) begin
            if (man[i]) begin
                lead = ($clog2(WIDE_W))'(i);
            end
        end
    end

    // bring the leading one to the units position just above the point
    always_comb begin
        if (lead > POINT) begin
            norm  = man >> (lead - POINT);
            exp_n = exp + fp_exp_t'(lead - POINT);   // value too big, exponent up
        end else begin
            norm  = man << (POINT - lead);
            exp_n = exp - fp_exp_t'(POINT - lead);   // fractional, exponent down
        end
    end

    // hidden one dropped, bits below the fraction truncated
    assign word = (man == '0) ? FALSE_WORD
                              : {sign, exp_n, norm[POINT-1 -: FRAC_W]};

endmodule

// ==== hdl/fpu_pkg.sv ====
package fpu_pkg;

    // single precision word layout
    localparam int FP_W     = 32;
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int EXP_BIAS = 127;

    // working mantissa, integer part in the upper half
    localparam int WIDE_W   = 64;
    localparam int POINT    = 32;   // bit index of the binary point

    typedef logic [FP_W-1:0]          fp_word_t;
    typedef logic signed [FP_W-1:0]   int_word_t;   // two's complement integer
    typedef logic [EXP_W-1:0]         fp_exp_t;
    typedef logic [WIDE_W-1:0]        wide_man_t;

    // comparison results
    localparam fp_word_t TRUE_WORD  = '1;
    localparam fp_word_t FALSE_WORD = '0;

    // opcodes, 0 and 3 left unused
    typedef enum logic [3:0] {
        OP_ADD = 4'd1,
        OP_MUL = 4'd2,
        OP_ITF = 4'd4,   // int to float
        OP_FTI = 4'd5,   // float to int
        OP_GT  = 4'd6,
        OP_LT  = 4'd7,
        OP_NE  = 4'd8,
        OP_EQ  = 4'd9
    } fpu_op_e;

endpackage

// ==== hdl/fpu_top.sv ====
`timescale 1ns/1ps

module fpu_top (
    input  logic              clk,
    input  logic              rst,
    input  fpu_pkg::fpu_op_e  op,
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    output fpu_pkg::fp_word_t c
);
    import fpu_pkg::*;

    fp_word_t  sum;
    fp_word_t  prod;
    fp_word_t  itf;
    int_word_t fti;
    logic      gt;
    logic      lt;
    logic      eq;
    fp_word_t  c_next;

    fp_add u_add (
        .a   (a),
        .b   (b),
        .sum (sum)
    );

    fp_mul u_mul (
        .a    (a),
        .b    (b),
        .prod (prod)
    );

    fp_convert u_conv (
        .a   (a),
        .itf (itf),
        .fti (fti)
    );

    fp_compare u_cmp (
        .a  (a),
        .b  (b),
        .gt (gt),
        .lt (lt),
        .eq (eq)
    );

    // result select
    always_comb begin
        case (op)
            OP_ADD:  c_next = sum;
            OP_MUL:  c_next = prod;
            OP_ITF:  c_next = itf;
            OP_FTI:  c_next = fp_word_t'(fti);   // raw integer bits
            OP_GT:   c_next = gt ? TRUE_WORD : FALSE_WORD;
            OP_LT:   c_next = lt ? TRUE_WORD : FALSE_WORD;
            OP_NE:   c_next = eq ? FALSE_WORD : TRUE_WORD;
            OP_EQ:   c_next = eq ? TRUE_WORD : FALSE_WORD;
            default: c_next = FALSE_WORD;        // 0, 3, 10..15
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            c <= '0;
        end else begin
            c <= c_next;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the fpu testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module fpu_tb -o fpu_sim || exit 1

# assertion errors are counted by the simulator instead of stopping the run
out=$(./obj_dir/fpu_sim +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -q -x -F ">>> PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
